/* verilog/rv_pkg.sv */
/*
  shared types and encodings for the rv32i subset pipeline
  each rtl module pulls these in with a wildcard import in its header
*/
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;      // data or instruction word
  typedef logic [4:0]  reg_addr_t;  // register index
  typedef logic [6:0]  opcode_t;    // major opcode field
  typedef logic [3:0]  alu_fn_t;    // internal alu function
  typedef logic [1:0]  fwd_sel_t;   // operand source in execute

  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;  // ecall only

  localparam alu_fn_t ALU_ADD = 4'd0;
  localparam alu_fn_t ALU_SUB = 4'd1;
  localparam alu_fn_t ALU_AND = 4'd2;
  localparam alu_fn_t ALU_OR  = 4'd3;
  localparam alu_fn_t ALU_XOR = 4'd4;
  localparam alu_fn_t ALU_SLT = 4'd5;  // signed compare
  localparam alu_fn_t ALU_SLL = 4'd6;
  localparam alu_fn_t ALU_SRL = 4'd7;

  localparam fwd_sel_t FWD_RF  = 2'd0;  // value read in decode
  localparam fwd_sel_t FWD_WB  = 2'd1;  // memory/writeback result
  localparam fwd_sel_t FWD_MEM = 2'd2;  // execute/memory alu result

endpackage

`default_nettype wire

/* verilog/rv_imem.sv */
/*
  instruction memory, written one word per program-load strobe
  fetch reads combinationally at the byte address of pc
*/
`default_nettype none

module rv_imem import rv_pkg::*; #(
  parameter int IMEM_WORDS = 64
) (
  input  logic  clk,
  input  logic  we,
  input  word_t waddr,  // word index
  input  word_t wdata,
  input  word_t raddr,  // byte address
  output word_t rdata
);

  localparam int AW = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1;

  word_t mem [IMEM_WORDS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[AW-1:0]] <= wdata;
    end
  end

  assign rdata = mem[raddr[AW+1:2]];  // word aligned fetch

  a_load_in_range: assert property (@(posedge clk) we |-> waddr < IMEM_WORDS)
    else $error("imem load to word %0d, depth is %0d", waddr, IMEM_WORDS);

endmodule

`default_nettype wire

/* verilog/rv_decoder.sv */
/*
  main control for the supported opcodes plus the sign-extended immediate
  anything outside the subset comes out as a bubble with no control bits
*/
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output logic      uses_rs1,
  output logic      uses_rs2,
  output logic      reg_write,
  output logic      alu_src_imm,
  output logic      mem_read,
  output logic      mem_write,
  output logic      is_ecall,
  output word_t     imm
);

  opcode_t opcode;

  assign opcode = inst[6:0];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  always_comb begin
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    reg_write   = 1'b0;
    alu_src_imm = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_ecall    = 1'b0;
    case (opcode)
      OPC_OP: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        uses_rs1    = 1'b1;
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
      end
      OPC_LOAD: begin
        uses_rs1    = 1'b1;
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        mem_read    = 1'b1;
      end
      OPC_STORE: begin
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;  // store data
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      OPC_SYSTEM: begin
        is_ecall = (inst[14:12] == 3'b000);
      end
      default: begin
      end
    endcase
  end

  // s-type splits the offset around rd
  assign imm = (opcode == OPC_STORE) ? {{20{inst[31]}}, inst[31:25], inst[11:7]}
                                     : {{20{inst[31]}}, inst[31:20]};

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
/*
  32-entry integer register file with two read ports and one write port
  a read of the register written in the same cycle sees the new value
*/
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      we,
  input  word_t     wdata,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // write-through bypass
  assign rs1_data = (rs1 == '0) ? '0 : (we && rs1 == rd) ? wdata : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && rs2 == rd) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
/*
  alu function control and datapath for the execute stage
  loads and stores use add for the address, other opcodes decode funct bits
*/
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  opcode_t    opcode,
  input  logic [2:0] funct3,
  input  logic       funct7_5,
  input  word_t      a,
  input  word_t      b,
  output word_t      result
);

  alu_fn_t fn;
  logic    arith;   // op or op-imm
  logic    fn_ok;

  assign arith = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);

  always_comb begin
    fn    = ALU_ADD;
    fn_ok = 1'b1;
    if (arith) begin
      case (funct3)
        3'b000:  fn = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
        3'b111:  fn = ALU_AND;
        3'b110:  fn = ALU_OR;
        3'b100:  fn = ALU_XOR;
        3'b010:  fn = ALU_SLT;
        3'b001:  fn = ALU_SLL;
        3'b101:  fn = ALU_SRL;
        default: fn_ok = 1'b0;  // sltu
      endcase
      // no immediate shifts and no sra in this subset
      if (opcode == OPC_OP_IMM && (funct3 == 3'b001 || funct3 == 3'b101)) begin
        fn_ok = 1'b0;
      end
      if (opcode == OPC_OP && funct7_5 && funct3 != 3'b000) begin
        fn_ok = 1'b0;
      end
    end
  end

  always_comb begin
    case (fn)
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLL: result = a << b[4:0];
      ALU_SRL: result = a >> b[4:0];
      default: result = a + b;
    endcase
  end

  a_fn_defined: assert final ($isunknown(opcode) || !arith || fn_ok)
    else $error("no alu function for opcode %b funct3 %b", opcode, funct3);

endmodule

`default_nettype wire

/* verilog/rv_hazard_unit.sv */
/*
  forwarding selects for the execute operands and the load-use stall
  the newest producer wins, and x0 never forwards
*/
`default_nettype none

module rv_hazard_unit import rv_pkg::*; (
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  logic      id_uses_rs1,
  input  logic      id_uses_rs2,
  input  reg_addr_t ex_rs1,
  input  reg_addr_t ex_rs2,
  input  reg_addr_t ex_rd,
  input  logic      ex_mem_read,
  input  reg_addr_t mem_rd,
  input  logic      mem_reg_write,
  input  reg_addr_t wb_rd,
  input  logic      wb_reg_write,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b,
  output logic      stall
);

  function automatic fwd_sel_t src_sel(reg_addr_t src);
    if (mem_reg_write && mem_rd != '0 && mem_rd == src) begin
      return FWD_MEM;
    end
    if (wb_reg_write && wb_rd != '0 && wb_rd == src) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign fwd_a = src_sel(ex_rs1);
  assign fwd_b = src_sel(ex_rs2);  // also the store data

  // load result is not ready until writeback, so hold decode one cycle
  assign stall = ex_mem_read && ex_rd != '0 &&
                 ((id_uses_rs1 && id_rs1 == ex_rd) || (id_uses_rs2 && id_rs2 == ex_rd));

endmodule

`default_nettype wire

/* verilog/rv_dmem.sv */
/*
  word data memory for lw and sw, single cycle
  reads are combinational, writes land at the clock edge, reset clears it
*/
`default_nettype none

module rv_dmem import rv_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  word_t addr,  // byte address
  input  logic  we,
  input  word_t wdata,
  output word_t rdata
);

  localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  word_t mem [DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[addr[AW+1:2]] <= wdata;
    end
  end

  assign rdata = mem[addr[AW+1:2]];

  a_store_in_range: assert property (@(posedge clk) disable iff (reset)
    we |-> addr[31:2] < DMEM_WORDS)
    else $error("store to word %0d, depth is %0d", addr[31:2], DMEM_WORDS);

endmodule

`default_nettype wire

/* verilog/rv_pipeline.sv */
/*
  five-stage in-order core for the rv32i subset
  load the program with prog_we while run is low, then raise run
  each register write retires as a wb_valid strobe, ecall ends with halted
*/
`default_nettype none

module rv_pipeline import rv_pkg::*; #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      prog_we,
  input  word_t     prog_addr,  // word index
  input  word_t     prog_data,
  input  logic      run,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      halted
);

  word_t pc;
  word_t imem_rdata;
  logic  stall;
  logic  stop;   // ecall in writeback or already halted
  logic  id_go;  // decode instruction moves on this cycle

  logic  ifid_valid;
  word_t ifid_inst;

  reg_addr_t d_rs1, d_rs2, d_rd;
  logic      d_uses_rs1, d_uses_rs2, d_reg_write, d_alu_src_imm;
  logic      d_mem_read, d_mem_write, d_is_ecall;
  word_t     d_imm, rs1_data, rs2_data;

  logic       idex_valid, idex_reg_write, idex_alu_src_imm;
  logic       idex_mem_read, idex_mem_write, idex_is_ecall;
  opcode_t    idex_opcode;
  logic [2:0] idex_funct3;
  logic       idex_funct7_5;
  reg_addr_t  idex_rs1, idex_rs2, idex_rd;
  word_t      idex_rs1_data, idex_rs2_data, idex_imm;

  fwd_sel_t fwd_a, fwd_b;
  word_t    op_a, op_b, rs2_fwd, alu_result;

  logic      exmem_valid, exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_is_ecall;
  reg_addr_t exmem_rd;
  word_t     exmem_alu, exmem_store_data, dmem_rdata;

  logic      memwb_valid, memwb_reg_write, memwb_mem_read, memwb_is_ecall;
  reg_addr_t memwb_rd;
  word_t     memwb_alu, memwb_load_data, wb_value;

  // everything freezes once ecall reaches writeback, younger work never retires
  assign stop  = halted || (memwb_valid && memwb_is_ecall);
  assign id_go = ifid_valid && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run && !stall && !stop) begin
      pc <= pc + 32'd4;
    end
  end

  rv_imem #(.IMEM_WORDS(IMEM_WORDS)) i_rv_imem (
    .clk   (clk),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (pc),
    .rdata (imem_rdata)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ifid_valid <= 1'b0;
    end else if (!stall && !stop) begin
      ifid_valid <= run;  // nothing enters decode before run
      ifid_inst  <= imem_rdata;
    end
  end

  rv_decoder i_rv_decoder (
    .inst        (ifid_inst),
    .rs1         (d_rs1),
    .rs2         (d_rs2),
    .rd          (d_rd),
    .uses_rs1    (d_uses_rs1),
    .uses_rs2    (d_uses_rs2),
    .reg_write   (d_reg_write),
    .alu_src_imm (d_alu_src_imm),
    .mem_read    (d_mem_read),
    .mem_write   (d_mem_write),
    .is_ecall    (d_is_ecall),
    .imm         (d_imm)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rd       (memwb_rd),
    .we       (memwb_reg_write),
    .wdata    (wb_value),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_hazard_unit i_rv_hazard_unit (
    .id_rs1        (d_rs1),
    .id_rs2        (d_rs2),
    .id_uses_rs1   (ifid_valid && d_uses_rs1),
    .id_uses_rs2   (ifid_valid && d_uses_rs2),
    .ex_rs1        (idex_rs1),
    .ex_rs2        (idex_rs2),
    .ex_rd         (idex_rd),
    .ex_mem_read   (idex_mem_read),
    .mem_rd        (exmem_rd),
    .mem_reg_write (exmem_reg_write),
    .wb_rd         (memwb_rd),
    .wb_reg_write  (memwb_reg_write),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .stall         (stall)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      idex_valid       <= 1'b0;
      idex_opcode      <= '0;
      idex_reg_write   <= 1'b0;
      idex_alu_src_imm <= 1'b0;
      idex_mem_read    <= 1'b0;
      idex_mem_write   <= 1'b0;
      idex_is_ecall    <= 1'b0;
    end else if (!stop) begin
      idex_valid       <= id_go;  // bubble while stalled
      idex_opcode      <= id_go ? ifid_inst[6:0] : '0;
      idex_reg_write   <= id_go && d_reg_write;
      idex_alu_src_imm <= id_go && d_alu_src_imm;
      idex_mem_read    <= id_go && d_mem_read;
      idex_mem_write   <= id_go && d_mem_write;
      idex_is_ecall    <= id_go && d_is_ecall;
      idex_funct3      <= ifid_inst[14:12];
      idex_funct7_5    <= ifid_inst[30];
      idex_rs1         <= d_rs1;
      idex_rs2         <= d_rs2;
      idex_rd          <= d_rd;
      idex_rs1_data    <= rs1_data;
      idex_rs2_data    <= rs2_data;
      idex_imm         <= d_imm;
    end
  end

  assign op_a    = (fwd_a == FWD_MEM) ? exmem_alu :
                   (fwd_a == FWD_WB)  ? wb_value  : idex_rs1_data;
  assign rs2_fwd = (fwd_b == FWD_MEM) ? exmem_alu :
                   (fwd_b == FWD_WB)  ? wb_value  : idex_rs2_data;
  assign op_b    = idex_alu_src_imm ? idex_imm : rs2_fwd;

  rv_alu i_rv_alu (
    .opcode   (idex_opcode),
    .funct3   (idex_funct3),
    .funct7_5 (idex_funct7_5),
    .a        (op_a),
    .b        (op_b),
    .result   (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      exmem_valid     <= 1'b0;
      exmem_reg_write <= 1'b0;
      exmem_mem_read  <= 1'b0;
      exmem_mem_write <= 1'b0;
      exmem_is_ecall  <= 1'b0;
    end else if (!stop) begin
      exmem_valid      <= idex_valid;
      exmem_reg_write  <= idex_reg_write;
      exmem_mem_read   <= idex_mem_read;
      exmem_mem_write  <= idex_mem_write;
      exmem_is_ecall   <= idex_is_ecall;
      exmem_rd         <= idex_rd;
      exmem_alu        <= alu_result;
      exmem_store_data <= rs2_fwd;
    end
  end

  rv_dmem #(.DMEM_WORDS(DMEM_WORDS)) i_rv_dmem (
    .clk   (clk),
    .reset (reset),
    .addr  (exmem_alu),
    .we    (exmem_mem_write && !stop),  // no store behind a retiring ecall
    .wdata (exmem_store_data),
    .rdata (dmem_rdata)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      memwb_valid     <= 1'b0;
      memwb_reg_write <= 1'b0;
      memwb_mem_read  <= 1'b0;
      memwb_is_ecall  <= 1'b0;
    end else if (!stop) begin
      memwb_valid     <= exmem_valid;
      memwb_reg_write <= exmem_reg_write;
      memwb_mem_read  <= exmem_mem_read;
      memwb_is_ecall  <= exmem_is_ecall;
      memwb_rd        <= exmem_rd;
      memwb_alu       <= exmem_alu;
      memwb_load_data <= dmem_rdata;
    end
  end

  assign wb_value = memwb_mem_read ? memwb_load_data : memwb_alu;

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (memwb_valid && memwb_is_ecall) begin
      halted <= 1'b1;
    end
  end

  assign wb_valid = memwb_valid && memwb_reg_write && memwb_rd != '0;
  assign wb_rd    = memwb_rd;
  assign wb_data  = wb_value;

  // the bubble sent on a stall clears the load from execute next cycle
  a_stall_once: assert property (@(posedge clk) disable iff (reset)
    stall && !stop |=> !stall)
    else $error("load-use stall held decode for a second cycle");

endmodule

`default_nettype wire

/* include/rv_iss.svh */
/*
  instruction encoders, random program generator and sequential reference
  model for the rv32i subset, included inside the testbench module after
  it imports the core package
*/
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

localparam int ISS_REGS      = 8;    // x0..x7 keeps dependencies dense
localparam int ISS_MEM_BYTES = 256;  // sw and lw offsets from x0 stay below this

localparam word_t ISS_ECALL = {25'b0, OPC_SYSTEM};

function automatic word_t encode_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t encode_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, opcode_t opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t encode_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

// mem_pct is the share of sw and lw in percent
function automatic word_t random_inst(int unsigned mem_pct);
  logic [2:0] r_f3 [8] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
  logic [2:0] i_f3 [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic [11:0] imm;
  int unsigned pick;
  int unsigned slot;
  rd  = reg_addr_t'($urandom_range(ISS_REGS - 1));
  rs1 = reg_addr_t'($urandom_range(ISS_REGS - 1));
  rs2 = reg_addr_t'($urandom_range(ISS_REGS - 1));
  imm = 12'($urandom_range(4095));
  if ($urandom_range(99) < mem_pct) begin
    slot = $urandom_range(ISS_MEM_BYTES / 4 - 1);
    if ($urandom_range(1) == 1) begin
      slot = $urandom_range(7);  // a few hot words so loads meet earlier stores
    end
    imm = 12'(slot * 4);
    if ($urandom_range(1) == 1) begin
      return encode_s(imm, rs2, 5'd0);
    end
    return encode_i(imm, 5'd0, 3'b010, rd, OPC_LOAD);
  end
  pick = $urandom_range(12);
  if (pick < 8) begin
    return encode_r((pick == 1) ? 7'h20 : 7'h00, rs2, rs1, r_f3[pick], rd);  // 1 is sub
  end
  return encode_i(imm, rs1, i_f3[pick - 8], rd, OPC_OP_IMM);
endfunction

function automatic void build_program(int unsigned len, int unsigned mem_pct,
                                      ref word_t prog[$]);
  prog.delete();
  repeat (len) begin
    prog.push_back(random_inst(mem_pct));
  end
  prog.push_back(ISS_ECALL);
endfunction

function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b111:  return a & b;
    3'b110:  return a | b;
    3'b100:  return a ^ b;
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b001:  return a << b[4:0];
    default: return a >> b[4:0];
  endcase
endfunction

// runs to ecall and queues every write to a nonzero rd in program order
function automatic void run_model(const ref word_t prog[$], ref reg_addr_t exp_rd[$],
                                  ref word_t exp_data[$]);
  word_t     x [32];
  word_t     dm [ISS_MEM_BYTES / 4];
  word_t     inst;
  word_t     imm_i;
  word_t     imm_s;
  word_t     res;
  reg_addr_t rd;
  logic      wr;
  exp_rd.delete();
  exp_data.delete();
  foreach (x[i]) x[i] = '0;
  foreach (dm[i]) dm[i] = '0;
  foreach (prog[i]) begin
    inst  = prog[i];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    rd    = inst[11:7];
    wr    = 1'b1;
    res   = '0;
    if (inst[6:0] == OPC_SYSTEM) begin
      break;
    end
    case (inst[6:0])
      OPC_OP:     res = model_alu(inst[14:12], inst[30], x[inst[19:15]], x[inst[24:20]]);
      OPC_OP_IMM: res = model_alu(inst[14:12], 1'b0, x[inst[19:15]], imm_i);
      OPC_LOAD:   res = dm[(x[inst[19:15]] + imm_i) >> 2];
      OPC_STORE: begin
        dm[(x[inst[19:15]] + imm_s) >> 2] = x[inst[24:20]];
        wr = 1'b0;
      end
      default:    wr = 1'b0;
    endcase
    if (wr && rd != '0) begin
      x[rd] = res;
      exp_rd.push_back(rd);
      exp_data.push_back(res);
    end
  end
endfunction

`endif

/* dv/tb_rv_pipeline.sv */
/*
  testbench for the five-stage rv32i subset core
  loads random and directed programs, runs each to ecall and compares every
  retire strobe with a sequential reference model, with a reset between programs
*/
`default_nettype none

module tb_rv_pipeline import rv_pkg::*; ();

  `include "rv_iss.svh"

  localparam int ARITH_PROGS = 4;
  localparam int MEM_PROGS   = 4;
  localparam int PROG_LEN    = 40;  // random instructions before the ecall
  localparam int X0_LEN      = 6;
  localparam int STLD_LEN    = 8;
  localparam int TOTAL_INSTS = (ARITH_PROGS + MEM_PROGS) * (PROG_LEN + 1) + X0_LEN + STLD_LEN;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTS * 8 + 100;

  logic      clk;
  logic      reset;
  logic      prog_we;
  word_t     prog_addr;
  word_t     prog_data;
  logic      run;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halted;

  reg_addr_t exp_rd[$];    // expected writes in program order
  word_t     exp_data[$];
  int        strobes;
  int        errors;
  int        tests_run;
  int        tests_failed;

  rv_pipeline i_rv_pipeline (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .run       (run),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // retire monitor sampled on the falling edge
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      strobes++;
      if (wb_rd == '0) begin
        $display("retire strobe for x0 at time %0t", $time);
        errors++;
      end
      if (exp_rd.size() == 0) begin
        $display("retire of x%0d at time %0t with no write left to expect", wb_rd, $time);
        errors++;
      end else begin
        if (wb_rd !== exp_rd[0]) begin
          $display("FAILED time %0t wb_rd expected %0d actual %0d", $time, exp_rd[0], wb_rd);
          errors++;
        end
        if (wb_data !== exp_data[0]) begin
          $display("FAILED time %0t wb_data expected %08h actual %08h",
                   $time, exp_data[0], wb_data);
          errors++;
        end
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset   = 1'b1;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic load_program(const ref word_t prog[$]);
    foreach (prog[i]) begin
      @(posedge clk);
      #1;
      prog_we   = 1'b1;
      prog_addr = word_t'(i);
      prog_data = prog[i];
    end
    @(posedge clk);
    #1;
    prog_we = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("test %0d %s: ok, %0d writes retired", tests_run, name, strobes);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  task automatic watch_idle(input int cycles);
    int err_start;
    err_start = errors;
    tests_run++;
    apply_reset();
    strobes = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (wb_valid !== 1'b0) begin
        $display("FAILED time %0t wb_valid expected 0 actual %b", $time, wb_valid);
        errors++;
      end
      if (halted !== 1'b0) begin
        $display("FAILED time %0t halted expected 0 actual %b", $time, halted);
        errors++;
      end
    end
    report_test("idle after reset", err_start);
  endtask

  task automatic run_program(input string name, const ref word_t prog[$]);
    int err_start;
    int n_exp;
    int limit;
    int waited;
    int seen;
    err_start = errors;
    tests_run++;
    limit  = prog.size() * 8 + 50;
    waited = 0;
    apply_reset();
    load_program(prog);
    run_model(prog, exp_rd, exp_data);
    n_exp   = exp_rd.size();
    strobes = 0;
    @(posedge clk);
    #1;
    run = 1'b1;
    while (!halted && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!halted) begin
      $display("halted did not rise within %0d cycles of run, time %0t", limit, $time);
      errors++;
    end else begin
      seen = strobes;
      repeat (20) @(negedge clk);  // core must stay quiet once halted
      if (!halted) begin
        $display("halted dropped without a reset, time %0t", $time);
        errors++;
      end
      if (strobes != seen) begin
        $display("%0d writes retired after halt, time %0t", strobes - seen, $time);
        errors++;
      end
      if (strobes != n_exp) begin
        $display("FAILED time %0t retire count expected %0d actual %0d", $time, n_exp, strobes);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    run = 1'b0;
    report_test(name, err_start);
  endtask

  initial begin
    word_t prog[$];
    reset        = 1'b1;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    run          = 1'b0;
    strobes      = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h6ee9_f24d));

    watch_idle(10);

    for (int n = 0; n < ARITH_PROGS; n++) begin
      build_program(PROG_LEN, 0, prog);
      run_program("random arithmetic", prog);
    end

    for (int n = 0; n < MEM_PROGS; n++) begin
      build_program(PROG_LEN, 60, prog);  // mostly sw and lw
      run_program("random load and store", prog);
    end

    // writes to x0 are dropped and later reads of x0 see zero
    prog.delete();
    prog.push_back(encode_i(12'h055, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
    prog.push_back(encode_i(12'h007, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    prog.push_back(encode_r(7'h00, 5'd2, 5'd2, 3'b110, 5'd0));
    prog.push_back(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
    prog.push_back(encode_r(7'h20, 5'd0, 5'd2, 3'b000, 5'd3));
    prog.push_back(ISS_ECALL);
    run_program("x0 writes", prog);

    // store then dependent load with load-use stalls and an alu result as store data
    prog.delete();
    prog.push_back(encode_i(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    prog.push_back(encode_s(12'd8, 5'd1, 5'd0));
    prog.push_back(encode_i(12'd8, 5'd0, 3'b010, 5'd2, OPC_LOAD));
    prog.push_back(encode_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
    prog.push_back(encode_s(12'd12, 5'd3, 5'd0));
    prog.push_back(encode_i(12'd12, 5'd0, 3'b010, 5'd4, OPC_LOAD));
    prog.push_back(encode_r(7'h00, 5'd2, 5'd4, 3'b100, 5'd5));
    prog.push_back(ISS_ECALL);
    run_program("store load chain", prog);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
verilog/rv_pkg.sv
verilog/rv_imem.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_hazard_unit.sv
verilog/rv_dmem.sv
verilog/rv_pipeline.sv
dv/tb_rv_pipeline.sv

/* Bender.yml */
package:
  name: rv_pipeline

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/rv_imem.sv
      - verilog/rv_decoder.sv
      - verilog/rv_regfile.sv
      - verilog/rv_alu.sv
      - verilog/rv_hazard_unit.sv
      - verilog/rv_dmem.sv
      - verilog/rv_pipeline.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_rv_pipeline.sv
